// File: files.f
design/parking_pkg.sv
design/tick_clock.sv
design/ticket_lfsr.sv
design/parking_spot.sv
design/lot_controller.sv
design/pay_station.sv
design/parking_top.sv
verif/parking_tb.sv

// File: verif/parking_tb.sv
`timescale 1ns/100ps
`default_nettype none

module parking_tb import parking_pkg::*; ();

	typedef enum logic [1:0] {
		op_park,
		op_pick,
		op_coin,
		op_wait
	} op_t;

	localparam int NUM_ENTRIES = 20;
	// budget per table entry covers gaps and tick waits
	localparam int CYCLE_LIMIT = 200 * NUM_ENTRIES;

	logic      CLOCK_50;
	logic      rst;
	logic      cmd_req;
	cmd_t      cmd;
	spot_idx_t spot;
	vsize_t    vsize;
	password_t password;
	logic      cmd_ack;
	status_t   status;
	password_t ticket;
	money_t    fare;
	logic      coin_req;
	money_t    coin;
	logic      coin_ack;
	money_t    paid_sum;
	money_t    change;
	logic      paid;
	time_t     lot_time;

	// stimulus table
	// value holds a coin or a tick count
	op_t       tbl_op [NUM_ENTRIES];
	spot_idx_t tbl_spot [NUM_ENTRIES];
	vsize_t    tbl_size [NUM_ENTRIES];
	logic      tbl_wrong [NUM_ENTRIES];
	money_t    tbl_value [NUM_ENTRIES];
	status_t   tbl_status [NUM_ENTRIES];
	int        n_loaded;

	// what the lot should remember per spot
	time_t     park_time [16];
	password_t tickets [16];
	vsize_t    park_size [16];
	// payment model
	logic      model_pending;
	money_t    model_fare;
	money_t    model_sum;

	// values captured at each ack
	status_t   got_status;
	password_t got_ticket;
	money_t    got_fare;
	time_t     got_time;
	money_t    got_sum;
	money_t    got_change;
	logic      got_paid;

	int        errors;
	int        checks;
	int        cycles;
	integer    seed;

	parking_top #(
		.NUM_SPOTS    (9),
		.SMALL_SPOTS  (6),
		.MEDIUM_SPOTS (2),
		.TICK_CYCLES  (16)
	) DUT (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.cmd_req  (cmd_req),
		.cmd      (cmd),
		.spot     (spot),
		.vsize    (vsize),
		.password (password),
		.cmd_ack  (cmd_ack),
		.status   (status),
		.ticket   (ticket),
		.fare     (fare),
		.coin_req (coin_req),
		.coin     (coin),
		.coin_ack (coin_ack),
		.paid_sum (paid_sum),
		.change   (change),
		.paid     (paid),
		.lot_time (lot_time)
	);

	// 8 ns period
	always #4 CLOCK_50 = ~CLOCK_50;

	// watchdog over the whole run
	always @(posedge CLOCK_50) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task check_value(input string name, input int actual, input int expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, actual, expected);
		end
	endtask

	task add_entry(input op_t op, input int s, input vsize_t sz, input logic wrong,
			input int value, input status_t st);
		tbl_op[n_loaded]     = op;
		tbl_spot[n_loaded]   = spot_idx_t'(s);
		tbl_size[n_loaded]   = sz;
		tbl_wrong[n_loaded]  = wrong;
		tbl_value[n_loaded]  = money_t'(value);
		tbl_status[n_loaded] = st;
		n_loaded++;
	endtask

	// fare from the rate table
	// saturates at the top of money_t
	function automatic money_t expected_fare(input vsize_t sz, input time_t stay_ticks);
		int rate_val;
		int prod;
		case (sz)
			size_small:  rate_val = RATE_SMALL;
			size_medium: rate_val = RATE_MEDIUM;
			default:     rate_val = RATE_LARGE;
		endcase
		prod = rate_val * stay_ticks;
		if (prod > 1023)
			return 10'h3ff;
		return money_t'(prod);
	endfunction

	function automatic string op_label(input op_t op);
		case (op)
			op_park: return "park";
			op_pick: return "pick";
			op_coin: return "coin";
			default: return "wait";
		endcase
	endfunction

	// four-phase command handshake
	// called on a falling edge
	task run_command(input cmd_t c, input spot_idx_t s, input vsize_t sz, input password_t pw);
		cmd      = c;
		spot     = s;
		vsize    = sz;
		password = pw;
		cmd_req  = 1'b1;
		@(negedge CLOCK_50);
		while (!cmd_ack)
			@(negedge CLOCK_50);
		got_status = status;
		got_ticket = ticket;
		got_fare   = fare;
		got_time   = lot_time;
		cmd_req    = 1'b0;
		@(negedge CLOCK_50);
		while (cmd_ack)
			@(negedge CLOCK_50);
	endtask

	// four-phase coin handshake
	task run_coin(input money_t value);
		coin     = value;
		coin_req = 1'b1;
		@(negedge CLOCK_50);
		while (!coin_ack)
			@(negedge CLOCK_50);
		got_sum    = paid_sum;
		got_change = change;
		got_paid   = paid;
		coin_req   = 1'b0;
		@(negedge CLOCK_50);
		while (coin_ack)
			@(negedge CLOCK_50);
	endtask

	task wait_ticks(input int n);
		time_t start;
		start = lot_time;
		while (time_t'(lot_time - start) < n)
			@(negedge CLOCK_50);
	endtask

	task load_table();
		n_loaded = 0;
		// coin with nothing owed
		add_entry(op_coin, 0, size_small, 1'b0, 7, st_ok);
		// parks that succeed
		add_entry(op_park, 0, size_small, 1'b0, 0, st_ok);
		add_entry(op_park, 8, size_large, 1'b0, 0, st_ok);
		// park errors
		add_entry(op_park, 0, size_medium, 1'b0, 0, st_occupied);
		add_entry(op_park, 6, size_large, 1'b0, 0, st_too_small);
		add_entry(op_park, 9, size_small, 1'b0, 0, st_bad_spot);
		// pick errors
		// spot 0 stays taken after a bad password
		add_entry(op_pick, 3, size_small, 1'b0, 0, st_empty);
		add_entry(op_pick, 0, size_small, 1'b1, 0, st_bad_password);
		add_entry(op_park, 0, size_small, 1'b0, 0, st_occupied);
		add_entry(op_park, 6, size_medium, 1'b0, 0, st_ok);
		// let a few ticks pass so the fare beats the first coins
		add_entry(op_wait, 0, size_small, 1'b0, 3, st_ok);
		add_entry(op_pick, 8, size_large, 1'b0, 0, st_ok);
		// fare outstanding
		add_entry(op_park, 1, size_small, 1'b0, 0, st_busy);
		add_entry(op_pick, 0, size_small, 1'b0, 0, st_busy);
		add_entry(op_coin, 0, size_small, 1'b0, 1, st_ok);
		add_entry(op_coin, 0, size_small, 1'b0, 2, st_ok);
		add_entry(op_coin, 0, size_small, 1'b0, 600, st_ok);
		// spot 8 free again
		add_entry(op_park, 8, size_large, 1'b0, 0, st_ok);
		add_entry(op_pick, 0, size_small, 1'b0, 0, st_ok);
		add_entry(op_coin, 0, size_small, 1'b0, 1000, st_ok);
	endtask

	// predict the coin result and compare
	task apply_coin(input money_t value);
		int sum_int;
		run_coin(value);
		if (model_pending) begin
			sum_int = model_sum + value;
			model_sum = (sum_int > 1023) ? 10'h3ff : money_t'(sum_int);
		end
		check_value("paid_sum", got_sum, model_sum);
		if (model_pending && (model_sum >= model_fare)) begin
			check_value("paid", got_paid, 1);
			check_value("change", got_change, model_sum - model_fare);
			model_pending = 1'b0;
		end else begin
			check_value("paid", got_paid, 0);
		end
	endtask

	task apply_command(input int i);
		password_t pw;
		time_t     stay_ticks;
		money_t    exp_fare;
		spot_idx_t s;
		s  = tbl_spot[i];
		pw = tbl_wrong[i] ? ~tickets[s] : tickets[s];
		run_command((tbl_op[i] == op_park) ? cmd_park : cmd_pick, s, tbl_size[i], pw);
		check_value("status", got_status, tbl_status[i]);
		if (got_status == st_ok && tbl_status[i] == st_ok) begin
			if (tbl_op[i] == op_park) begin
				// lfsr never hands out zero
				check_value("ticket_nonzero", got_ticket != '0, 1);
				// remember ticket and entry time for the pick
				tickets[s]   = got_ticket;
				park_time[s] = got_time;
				park_size[s] = tbl_size[i];
			end else begin
				stay_ticks = time_t'(got_time - park_time[s]);
				exp_fare   = expected_fare(park_size[s], stay_ticks);
				check_value("fare", got_fare, exp_fare);
				model_fare    = exp_fare;
				model_pending = 1'b1;
				model_sum     = '0;
			end
		end
	endtask

	initial begin
		int i;
		int gap;
		int errors_before;
		seed          = 4662;
		errors        = 0;
		checks        = 0;
		cycles        = 0;
		model_pending = 1'b0;
		model_fare    = '0;
		model_sum     = '0;
		CLOCK_50      = 1'b0;
		rst           = 1'b1;
		cmd_req       = 1'b0;
		cmd           = cmd_park;
		spot          = '0;
		vsize         = size_small;
		password      = '0;
		coin_req      = 1'b0;
		coin          = '0;
		for (i = 0; i < 16; i++) begin
			park_time[i] = '0;
			tickets[i]   = '0;
			park_size[i] = size_small;
		end
		load_table();

		// reset for 3 cycles
		// release on a falling edge
		repeat (3) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst = 1'b0;
		check_value("lot_time", lot_time, 0);
		check_value("cmd_ack", cmd_ack, 0);
		check_value("coin_ack", coin_ack, 0);
		check_value("paid", paid, 0);
		check_value("status", status, st_ok);
		check_value("fare", fare, 0);
		$display("test reset: %0d mismatches", errors);

		for (i = 0; i < n_loaded; i++) begin
			// random idle gap of at least one cycle
			gap = 1 + ($unsigned($random(seed)) % 16);
			repeat (gap) @(negedge CLOCK_50);
			errors_before = errors;
			case (tbl_op[i])
				op_coin: apply_coin(tbl_value[i]);
				op_wait: wait_ticks(tbl_value[i]);
				default: apply_command(i);
			endcase
			$display("test %0d %s spot %0d: %0d mismatches", i, op_label(tbl_op[i]),
				tbl_spot[i], errors - errors_before);
		end

		$display("tests: %0d, checks: %0d, mismatches: %0d", n_loaded + 1, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/parking_top.sv
`timescale 1ns/100ps
`default_nettype none

module parking_top import parking_pkg::*; #(
	parameter int NUM_SPOTS    = 9,
	parameter int SMALL_SPOTS  = 6,
	parameter int MEDIUM_SPOTS = 2,
	parameter int TICK_CYCLES  = 50_000_000
) (
	input  logic      CLOCK_50,
	input  logic      rst,
	input  logic      cmd_req,
	input  cmd_t      cmd,
	input  spot_idx_t spot,
	input  vsize_t    vsize,
	input  password_t password,
	output logic      cmd_ack,
	output status_t   status,
	output password_t ticket,
	output money_t    fare,
	input  logic      coin_req,
	input  money_t    coin,
	output logic      coin_ack,
	output money_t    paid_sum,
	output money_t    change,
	output logic      paid,
	output time_t     lot_time
);

	logic                 tick;
	password_t            lfsr_value;
	// per-spot flags back to the controller
	logic [NUM_SPOTS-1:0] occupied;
	logic [NUM_SPOTS-1:0] fits;
	logic [NUM_SPOTS-1:0] pass_ok;
	time_t                entry_times [NUM_SPOTS];
	vsize_t               stored_sizes [NUM_SPOTS];
	// one-hot strobes into the spot array
	logic [NUM_SPOTS-1:0] park_en;
	logic [NUM_SPOTS-1:0] leave_en;
	// fare request towards the pay station
	logic                 fare_load;
	time_t                stay;
	vsize_t               fare_size;
	logic                 leave_done;

	// any spot released ends the payment
	assign leave_done = |leave_en;

	tick_clock #(
		.TICK_CYCLES(TICK_CYCLES)
	) u_tick_clock (
		.CLOCK_50 (CLOCK_50),
		.rst      (rst),
		.tick     (tick),
		.lot_time (lot_time)
	);

	ticket_lfsr u_ticket_lfsr (
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.lfsr_value (lfsr_value)
	);

	lot_controller #(
		.NUM_SPOTS(NUM_SPOTS)
	) u_lot_controller (
		.CLOCK_50     (CLOCK_50),
		.rst          (rst),
		.cmd_req      (cmd_req),
		.cmd          (cmd),
		.spot         (spot),
		.lot_time     (lot_time),
		.tick         (tick),
		.lfsr_value   (lfsr_value),
		.occupied     (occupied),
		.fits         (fits),
		.pass_ok      (pass_ok),
		.entry_times  (entry_times),
		.stored_sizes (stored_sizes),
		.paid         (paid),
		.cmd_ack      (cmd_ack),
		.status       (status),
		.ticket       (ticket),
		.park_en      (park_en),
		.leave_en     (leave_en),
		.fare_load    (fare_load),
		.stay         (stay),
		.fare_size    (fare_size)
	);

	// spot array, sizes run small, then medium, then large
	generate
		for (genvar i = 0; i < NUM_SPOTS; i++) begin : g_spot
			localparam vsize_t SIZE = (i < SMALL_SPOTS) ? size_small :
				(i < SMALL_SPOTS + MEDIUM_SPOTS) ? size_medium : size_large;

			parking_spot #(
				.SPOT_SIZE(SIZE)
			) u_spot (
				.CLOCK_50    (CLOCK_50),
				.rst         (rst),
				.park_en     (park_en[i]),
				.leave_en    (leave_en[i]),
				.vsize       (vsize),
				.password    (password),
				.lfsr_value  (lfsr_value),
				.lot_time    (lot_time),
				.occupied    (occupied[i]),
				.fits        (fits[i]),
				.pass_ok     (pass_ok[i]),
				.entry_time  (entry_times[i]),
				.stored_size (stored_sizes[i])
			);
		end
	endgenerate

	pay_station u_pay_station (
		.CLOCK_50   (CLOCK_50),
		.rst        (rst),
		.fare_load  (fare_load),
		.stay       (stay),
		.fare_size  (fare_size),
		.coin_req   (coin_req),
		.coin       (coin),
		.leave_done (leave_done),
		.fare       (fare),
		.coin_ack   (coin_ack),
		.paid_sum   (paid_sum),
		.change     (change),
		.paid       (paid)
	);

endmodule

`default_nettype wire

// File: design/pay_station.sv
`timescale 1ns/100ps
`default_nettype none

module pay_station import parking_pkg::*; (
	input  logic   CLOCK_50,
	input  logic   rst,
	input  logic   fare_load,
	input  time_t  stay,
	input  vsize_t fare_size,
	input  logic   coin_req,
	input  money_t coin,
	input  logic   leave_done,
	output money_t fare,
	output logic   coin_ack,
	output money_t paid_sum,
	output money_t change,
	output logic   paid
);

	money_t      rate;
	logic [18:0] product;
	logic [10:0] sum_next;
	// fare outstanding
	logic        pending;
	// coin taken, ack goes out next cycle
	logic        adding;

	always_comb begin
		case (fare_size)
			size_small:  rate = RATE_SMALL;
			size_medium: rate = RATE_MEDIUM;
			size_large:  rate = RATE_LARGE;
			default:     rate = RATE_LARGE;
		endcase
	end

	assign product  = rate * stay;
	assign sum_next = {1'b0, paid_sum} + coin;

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			fare     <= '0;
			pending  <= 1'b0;
			adding   <= 1'b0;
			coin_ack <= 1'b0;
			paid_sum <= '0;
			change   <= '0;
			paid     <= 1'b0;
		end else begin
			if (fare_load) begin
				// saturate at the top of money_t
				fare     <= (product > 19'(10'h3ff)) ? 10'h3ff : product[9:0];
				pending  <= 1'b1;
				paid_sum <= '0;
				change   <= '0;
			end

			// new coin, sum only moves with a fare outstanding
			if (coin_req && !coin_ack && !adding) begin
				adding <= 1'b1;
				if (pending)
					paid_sum <= sum_next[10] ? 10'h3ff : sum_next[9:0];
			end

			// ack with sum, change and paid valid
			if (adding) begin
				adding   <= 1'b0;
				coin_ack <= 1'b1;
				if (pending && (paid_sum >= fare)) begin
					paid    <= 1'b1;
					change  <= paid_sum - fare;
					pending <= 1'b0;
				end
			end

			if (coin_ack && !coin_req)
				coin_ack <= 1'b0;

			// spot freed, fare settled
			if (leave_done) begin
				paid <= 1'b0;
				fare <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/lot_controller.sv
`timescale 1ns/100ps
`default_nettype none

module lot_controller import parking_pkg::*; #(
	parameter int NUM_SPOTS = 9
) (
	input  logic                 CLOCK_50,
	input  logic                 rst,
	input  logic                 cmd_req,
	input  cmd_t                 cmd,
	input  spot_idx_t            spot,
	input  time_t                lot_time,
	input  logic                 tick,
	input  password_t            lfsr_value,
	input  logic [NUM_SPOTS-1:0] occupied,
	input  logic [NUM_SPOTS-1:0] fits,
	input  logic [NUM_SPOTS-1:0] pass_ok,
	input  time_t                entry_times [NUM_SPOTS],
	input  vsize_t               stored_sizes [NUM_SPOTS],
	input  logic                 paid,
	output logic                 cmd_ack,
	output status_t              status,
	output password_t            ticket,
	output logic [NUM_SPOTS-1:0] park_en,
	output logic [NUM_SPOTS-1:0] leave_en,
	output logic                 fare_load,
	output time_t                stay,
	output vsize_t               fare_size
);

	ctrl_state_t          state;
	status_t              chk_status;
	// set by a good pick, held until the fare is paid
	logic                 pending;
	spot_idx_t            pick_spot;
	spot_idx_t            sel;
	logic [NUM_SPOTS-1:0] sel_onehot;
	logic                 commit;
	logic                 park_ok;
	logic                 pick_ok;

	// out-of-range index folds to spot 0, result is discarded anyway
	assign sel        = (spot < NUM_SPOTS) ? spot : '0;
	assign sel_onehot = NUM_SPOTS'(1'b1) << sel;

	// result of the pending command, from the selected spot's flags
	always_comb begin
		chk_status = st_ok;
		if (pending) begin
			chk_status = st_busy;
		end else if (spot >= NUM_SPOTS) begin
			chk_status = st_bad_spot;
		end else if (cmd == cmd_park) begin
			if (occupied[sel])
				chk_status = st_occupied;
			else if (!fits[sel])
				chk_status = st_too_small;
		end else begin
			if (!occupied[sel])
				chk_status = st_empty;
			else if (!pass_ok[sel])
				chk_status = st_bad_password;
		end
	end

	// hold off while lot_time is about to step
	// so the stored time matches the time seen with ack
	assign commit  = (state == ctrl_decide) && !tick;
	assign park_ok = commit && (chk_status == st_ok) && (cmd == cmd_park);
	assign pick_ok = commit && (chk_status == st_ok) && (cmd == cmd_pick);

	// spot strobes, one cycle each
	assign park_en   = park_ok ? sel_onehot : '0;
	assign leave_en  = (state == ctrl_release) ? (NUM_SPOTS'(1'b1) << pick_spot) : '0;

	// fare request, stay wraps with the 9-bit clock
	assign fare_load = pick_ok;
	assign stay      = time_t'(lot_time - entry_times[sel]);
	assign fare_size = stored_sizes[sel];

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state   <= ctrl_idle;
			cmd_ack <= 1'b0;
			status  <= st_ok;
			ticket  <= '0;
			pending <= 1'b0;
		end else begin
			case (state)
				ctrl_idle: begin
					if (cmd_req)
						state <= ctrl_decide;
				end
				ctrl_decide: begin
					if (commit) begin
						cmd_ack <= 1'b1;
						status  <= chk_status;
						// same lfsr value the spot stores on this edge
						ticket  <= park_ok ? lfsr_value : '0;
						if (pick_ok)
							pending <= 1'b1;
						state   <= ctrl_ack;
					end
				end
				ctrl_ack: begin
					// four-phase, drop ack after req falls
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						state   <= pending ? ctrl_wait_pay : ctrl_idle;
					end
				end
				ctrl_wait_pay: begin
					// payment first, other commands get st_busy
					if (paid)
						state <= ctrl_release;
					else if (cmd_req)
						state <= ctrl_decide;
				end
				ctrl_release: begin
					pending <= 1'b0;
					state   <= ctrl_idle;
				end
				default: state <= ctrl_idle;
			endcase
		end
	end

	// spot waiting for payment
	always_ff @(posedge CLOCK_50) begin
		if (pick_ok)
			pick_spot <= sel;
	end

endmodule

`default_nettype wire

// File: design/parking_spot.sv
`timescale 1ns/100ps
`default_nettype none

module parking_spot import parking_pkg::*; #(
	parameter vsize_t SPOT_SIZE = size_small
) (
	input  logic      CLOCK_50,
	input  logic      rst,
	input  logic      park_en,
	input  logic      leave_en,
	input  vsize_t    vsize,
	input  password_t password,
	input  password_t lfsr_value,
	input  time_t     lot_time,
	output logic      occupied,
	output logic      fits,
	output logic      pass_ok,
	output time_t     entry_time,
	output vsize_t    stored_size
);

	password_t stored_pass;

	// occupancy, park wins over leave
	always_ff @(posedge CLOCK_50) begin
		if (rst)
			occupied <= 1'b0;
		else if (park_en)
			occupied <= 1'b1;
		else if (leave_en)
			occupied <= 1'b0;
	end

	// ticket data of the parked car
	always_ff @(posedge CLOCK_50) begin
		if (park_en) begin
			stored_size <= vsize;
			entry_time  <= lot_time;
			stored_pass <= lfsr_value;
		end
	end

	// small fits anywhere, medium needs medium or large
	// large needs a large spot
	always_comb begin
		case (vsize)
			size_small:  fits = 1'b1;
			size_medium: fits = (SPOT_SIZE != size_small);
			size_large:  fits = (SPOT_SIZE == size_large);
			default:     fits = 1'b0;
		endcase
	end

	// presented password against the ticket
	// only meaningful with a car in the spot
	assign pass_ok = occupied && (stored_pass == password);

endmodule

`default_nettype wire

// File: design/ticket_lfsr.sv
`timescale 1ns/100ps
`default_nettype none

module ticket_lfsr import parking_pkg::*; (
	input  logic      CLOCK_50,
	input  logic      rst,
	output password_t lfsr_value
);

	logic feedback;

	// x^10 + x^7 + 1, period 1023
	assign feedback = lfsr_value[9] ^ lfsr_value[6];

	// never reset to zero, that state locks up
	always_ff @(posedge CLOCK_50) begin
		if (rst)
			lfsr_value <= 10'h2a5;
		else
			lfsr_value <= {lfsr_value[8:0], feedback};
	end

endmodule

`default_nettype wire

// File: design/tick_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tick_clock import parking_pkg::*; #(
	parameter int TICK_CYCLES = 50_000_000
) (
	input  logic  CLOCK_50,
	input  logic  rst,
	output logic  tick,
	output time_t lot_time
);

	localparam int CNT_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

	logic [CNT_W-1:0] prescale;

	// high in the last cycle of each period, lot_time steps on this edge
	assign tick = (prescale == CNT_W'(TICK_CYCLES - 1));

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			prescale <= '0;
			lot_time <= '0;
		end else if (tick) begin
			prescale <= '0;
			// wraps at 512
			lot_time <= time_t'(lot_time + 1'b1);
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: design/parking_pkg.sv
`default_nettype none

package parking_pkg;

	// spot number, wide enough for 9 spots plus out-of-range requests
	typedef logic [3:0] spot_idx_t;

	// lot time in ticks, wraps at 512
	typedef logic [8:0] time_t;

	// ticket password handed out at park
	typedef logic [9:0] password_t;

	// fares, coin sums and change
	typedef logic [9:0] money_t;

	// vehicle size, also used as the size of a spot
	typedef enum logic [1:0] {
		size_small  = 2'd0,
		size_medium = 2'd1,
		size_large  = 2'd2
	} vsize_t;

	typedef enum logic {
		cmd_park = 1'b0,
		cmd_pick = 1'b1
	} cmd_t;

	// one result code per command
	typedef enum logic [2:0] {
		st_ok           = 3'd0,
		st_bad_spot     = 3'd1,
		st_occupied     = 3'd2,
		st_too_small    = 3'd3,
		st_empty        = 3'd4,
		st_bad_password = 3'd5,
		st_busy         = 3'd6
	} status_t;

	// money per tick for each vehicle size
	localparam money_t RATE_SMALL  = 10'd1;
	localparam money_t RATE_MEDIUM = 10'd2;
	localparam money_t RATE_LARGE  = 10'd3;

	// command FSM of the lot controller
	typedef enum logic [2:0] {
		ctrl_idle     = 3'd0,
		ctrl_decide   = 3'd1,
		ctrl_ack      = 3'd2,
		ctrl_wait_pay = 3'd3,
		ctrl_release  = 3'd4
	} ctrl_state_t;

endpackage

`default_nettype wire
